//--- src/flash_rd_pkg.sv
// flash geometry, flash word layout and read buffer entry types shared by
// the flash read pipeline stages
package flash_rd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////////////////////

  // a bus word is half a flash word
  localparam int unsigned BusW          = 32;
  localparam int unsigned DataW         = 64;
  // one even parity bit per data byte
  localparam int unsigned ParW          = 8;
  localparam int unsigned FlashWordW    = DataW + ParW;
  localparam int unsigned WordsPerFlash = DataW / BusW;

  // the low bus address bit picks the bus word inside a flash word
  localparam int unsigned WordAddrW     = 10;
  localparam int unsigned BusAddrW      = 11;
  // upper word address bits form the page, 64 flash words per page
  localparam int unsigned PageW         = 4;

  ////////////////////////////////////////////////////////////////////////////
  // flash word and buffer types
  ////////////////////////////////////////////////////////////////////////////

  // the parity check reads the whole word, the response picks a bus word
  typedef union packed {
    logic [DataW-1:0]                   whole;
    logic [WordsPerFlash-1:0][BusW-1:0] words;
  } flash_data_u;

  typedef struct packed {
    logic [ParW-1:0] par;
    flash_data_u     data;
  } flash_word_t;

  typedef enum logic [1:0] {
    Invalid = 2'b00,
    Wip     = 2'b01,
    Valid   = 2'b10
  } buf_state_e;

  // err holds the raw parity result of the read that filled the buffer
  typedef struct packed {
    buf_state_e           state;
    logic [WordAddrW-1:0] addr;
    logic                 err;
    flash_data_u          data;
  } buf_entry_t;

endpackage

//--- src/flash_rd_if_pkg.sv
// port structs for the bus-side request and response and for the flash
// macro interface of the read pipeline
package flash_rd_if_pkg;

  // bus-side request
  // prog, pg_erase and bk_erase are side commands without a handshake and
  // only mean something while the pipeline is idle
  typedef struct packed {
    logic                               req;
    logic [flash_rd_pkg::BusAddrW-1:0]  addr;
    logic                               ecc;
    logic                               prog;
    logic                               pg_erase;
    logic                               bk_erase;
  } rd_req_t;

  // one-cycle response strobe, the upstream always takes it
  typedef struct packed {
    logic                           valid;
    logic                           err;
    logic [flash_rd_pkg::BusW-1:0]  data;
  } rd_rsp_t;

  // read request to the flash macro, taken in the cycle where ack is high
  typedef struct packed {
    logic                               req;
    logic [flash_rd_pkg::WordAddrW-1:0] addr;
  } flash_req_t;

  // the word comes back on the done cycle
  typedef struct packed {
    logic                      ack;
    logic                      done;
    flash_rd_pkg::flash_word_t word;
  } flash_rsp_t;

endpackage

//--- src/flash_rd_ctrl.sv
// flash read FSM, tracks the one read in flight and holds its attributes
// until the macro returns done
`timescale 1ns/1ns

module flash_rd_ctrl #(
  parameter int unsigned NumBuf = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               start_i,
  input  logic                               done_i,
  input  logic [flash_rd_pkg::WordAddrW-1:0] addr_i,
  input  logic                               ecc_i,
  input  logic [NumBuf-1:0]                  alloc_i,
  output logic                               busy_o,
  output logic                               rd_done_o,
  output logic [flash_rd_pkg::WordAddrW-1:0] rd_addr_o,
  output logic                               rd_ecc_o,
  output logic [NumBuf-1:0]                  rd_alloc_o
);

  typedef enum logic {
    Idle,
    Busy
  } state_e;

  state_e state_q, state_d;

  assign busy_o = (state_q == Busy);

  // done is broadcast by the macro, it only counts with a read in flight
  assign rd_done_o = busy_o & done_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: if (start_i) state_d = Busy;
      // a new read may start in the same cycle the previous one finishes
      Busy: if (done_i) state_d = start_i ? Busy : Idle;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // attributes of the read in flight, the allocated buffer is where the
  // returning word goes
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rd_addr_o  <= addr_i;
      rd_ecc_o   <= ecc_i;
      rd_alloc_o <= alloc_i;
    end
  end

endmodule

//--- src/flash_rd_repl_ptr.sv
// round-robin pick among valid read buffers that have no queued response
`timescale 1ns/1ns

module flash_rd_repl_ptr #(
  parameter int unsigned NumBuf = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic [NumBuf-1:0] cand_i,
  input  logic              adv_i,
  output logic [NumBuf-1:0] pick_o
);

  localparam int unsigned PtrW = (NumBuf > 1) ? $clog2(NumBuf) : 1;

  logic [PtrW-1:0] ptr_q;
  logic [PtrW-1:0] pick_idx;

  // search from the pointer onward, walking the offsets downward so the
  // nearest candidate is the one left standing
  always_comb begin
    int unsigned idx;
    pick_o   = '0;
    pick_idx = ptr_q;
    for (int off = NumBuf - 1; off >= 0; off--) begin
      idx = (int'(ptr_q) + off) % NumBuf;
      if (cand_i[idx]) begin
        pick_o      = '0;
        pick_o[idx] = 1'b1;
        pick_idx    = PtrW'(idx);
      end
    end
  end

  // move just past the evicted buffer so it is the last to go again
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (adv_i) begin
      ptr_q <= (int'(pick_idx) == NumBuf - 1) ? '0 : pick_idx + 1'b1;
    end
  end

endmodule

//--- src/flash_rd_parity_chk.sv
// byte parity check on a returned flash word, erased words pass clean
`timescale 1ns/1ns

module flash_rd_parity_chk (
  input  flash_rd_pkg::flash_word_t word_i,
  output logic                      par_err_o,
  output logic                      erased_o
);

  localparam int unsigned ByteW = flash_rd_pkg::DataW / flash_rd_pkg::ParW;

  logic [flash_rd_pkg::ParW-1:0] byte_err;

  // an erased word reads as all ones, parity bits included
  assign erased_o = (word_i == {flash_rd_pkg::FlashWordW{1'b1}});

  // even parity, each parity bit equals the xor of its byte
  for (genvar i = 0; i < flash_rd_pkg::ParW; i++) begin : gen_byte
    assign byte_err[i] = (^word_i.data.whole[i*ByteW +: ByteW]) ^ word_i.par[i];
  end

  // all-ones bytes always miss even parity, so erased words are exempt
  assign par_err_o = ~erased_o & |byte_err;

endmodule

//--- src/flash_rd_order_fifo.sv
// response-order FIFO, one entry per accepted request naming the buffer
// and bus word that answer it
`timescale 1ns/1ns

module flash_rd_order_fifo #(
  parameter int unsigned NumBuf     = 4,
  parameter int unsigned OrderDepth = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              wr_i,
  input  logic [NumBuf-1:0] wr_sel_i,
  input  logic              wr_word_i,
  input  logic              wr_ecc_i,
  input  logic              rd_i,
  output logic              full_o,
  output logic              empty_o,
  output logic [NumBuf-1:0] head_sel_o,
  output logic              head_word_o,
  output logic              head_ecc_o,
  output logic [NumBuf-1:0] dep_o
);

  localparam int unsigned PtrW = (OrderDepth > 1) ? $clog2(OrderDepth) : 1;

  typedef struct packed {
    logic [NumBuf-1:0] sel;
    logic              word;
    logic              ecc;
  } entry_t;

  entry_t                mem_q [OrderDepth];
  entry_t                wr_entry;
  logic [OrderDepth-1:0] vld_q;
  logic [PtrW-1:0]       wptr_q;
  logic [PtrW-1:0]       rptr_q;
  logic                  do_wr;
  logic                  do_rd;

  // wrap at the depth, which need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    if (int'(ptr) == OrderDepth - 1) return '0;
    return ptr + 1'b1;
  endfunction

  // per-slot valid bits give full, empty and the dependency mask directly
  assign full_o   = &vld_q;
  assign empty_o  = ~|vld_q;
  assign do_wr    = wr_i & ~full_o;
  assign do_rd    = rd_i & ~empty_o;
  assign wr_entry = '{sel: wr_sel_i, word: wr_word_i, ecc: wr_ecc_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q  <= '0;
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (do_wr) begin
        vld_q[wptr_q] <= 1'b1;
        wptr_q        <= ptr_inc(wptr_q);
      end
      if (do_rd) begin
        vld_q[rptr_q] <= 1'b0;
        rptr_q        <= ptr_inc(rptr_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem_q[wptr_q] <= wr_entry;
    end
  end

  assign head_sel_o  = mem_q[rptr_q].sel;
  assign head_word_o = mem_q[rptr_q].word;
  assign head_ecc_o  = mem_q[rptr_q].ecc;

  // a buffer with a queued response must not be evicted
  always_comb begin
    dep_o = '0;
    for (int i = 0; i < OrderDepth; i++) begin
      if (vld_q[i]) dep_o = dep_o | mem_q[i].sel;
    end
  end

endmodule

//--- src/flash_rd_buf_array.sv
// read buffer storage with hit match, allocation, hazard wipe and fill on
// flash read completion
`timescale 1ns/1ns

module flash_rd_buf_array #(
  parameter int unsigned NumBuf = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   en_i,
  input  flash_rd_if_pkg::rd_req_t               req_i,
  input  logic                                   accept_i,
  input  logic [NumBuf-1:0]                      dep_i,
  input  logic [NumBuf-1:0]                      upd_sel_i,
  input  logic                                   upd_err_i,
  input  flash_rd_pkg::flash_data_u              upd_data_i,
  output logic [NumBuf-1:0]                      hit_o,
  output logic [NumBuf-1:0]                      alloc_o,
  output logic                                   all_dep_o,
  output flash_rd_pkg::buf_entry_t [NumBuf-1:0]  entries_o
);

  localparam int unsigned WordAddrW = flash_rd_pkg::WordAddrW;
  localparam int unsigned PageW     = flash_rd_pkg::PageW;

  // state carries the reset, the payload is only read once state allows it
  flash_rd_pkg::buf_state_e  state_q [NumBuf];
  logic [WordAddrW-1:0]      addr_q  [NumBuf];
  logic                      err_q   [NumBuf];
  flash_rd_pkg::flash_data_u data_q  [NumBuf];

  logic [WordAddrW-1:0] word_addr;
  logic [NumBuf-1:0]    is_valid;
  logic [NumBuf-1:0]    is_wip;
  logic [NumBuf-1:0]    is_free;
  logic [NumBuf-1:0]    free_first;
  logic [NumBuf-1:0]    repl_cand;
  logic [NumBuf-1:0]    repl_pick;
  logic [NumBuf-1:0]    wipe;
  logic [NumBuf-1:0]    alloc_we;
  logic [NumBuf-1:0]    upd_we;

  // drop the bus word select, buffers hold whole flash words
  assign word_addr = req_i.addr[flash_rd_pkg::BusAddrW-1 -: WordAddrW];

  ////////////////////////////////////////////////////////////////////////////
  // match and hazard per buffer
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumBuf; i++) begin : gen_match
    logic word_match;
    logic page_match;

    assign is_valid[i] = (state_q[i] == flash_rd_pkg::Valid);
    assign is_wip[i]   = (state_q[i] == flash_rd_pkg::Wip);

    // a valid buffer holding bad data is free once nothing waits on it
    assign is_free[i]  = (state_q[i] == flash_rd_pkg::Invalid) |
                         (is_valid[i] & err_q[i] & ~dep_i[i]);

    assign word_match = (addr_q[i] == word_addr);
    assign page_match = (addr_q[i][WordAddrW-1 -: PageW] == word_addr[WordAddrW-1 -: PageW]);

    // a hit on a wip buffer is answered once the flash word lands there
    assign hit_o[i] = req_i.req & en_i & (is_valid[i] | is_wip[i]) &
                      word_match & ~err_q[i];

    // wip buffers are never wiped, side commands only come while idle
    assign wipe[i] = is_valid[i] & (req_i.bk_erase |
                                    (req_i.prog & word_match) |
                                    (req_i.pg_erase & page_match));
  end

  ////////////////////////////////////////////////////////////////////////////
  // allocation
  ////////////////////////////////////////////////////////////////////////////

  // lowest free buffer first
  always_comb begin
    free_first = '0;
    for (int i = NumBuf - 1; i >= 0; i--) begin
      if (is_free[i]) begin
        free_first    = '0;
        free_first[i] = 1'b1;
      end
    end
  end

  assign all_dep_o = &dep_i;

  // only evict a valid buffer when nothing is free
  assign repl_cand = (|free_first | all_dep_o) ? '0 : is_valid & ~dep_i;

  flash_rd_repl_ptr #(
    .NumBuf(NumBuf)
  ) i_repl_ptr (
    .clk_i,
    .rst_ni,
    .cand_i(repl_cand),
    .adv_i (accept_i & |alloc_o & ~|free_first),
    .pick_o(repl_pick)
  );

  assign alloc_o = (req_i.req & en_i & ~|hit_o) ?
                   (|free_first ? free_first : repl_pick) : '0;

  ////////////////////////////////////////////////////////////////////////////
  // buffer update
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumBuf; i++) begin : gen_buf
    assign alloc_we[i] = accept_i & alloc_o[i];
    assign upd_we[i]   = upd_sel_i[i] & is_wip[i];

    // turning buffering off drops every entry
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        state_q[i] <= flash_rd_pkg::Invalid;
      end else if (!en_i) begin
        state_q[i] <= flash_rd_pkg::Invalid;
      end else if (alloc_we[i]) begin
        state_q[i] <= flash_rd_pkg::Wip;
      end else if (upd_we[i]) begin
        state_q[i] <= flash_rd_pkg::Valid;
      end else if (wipe[i]) begin
        state_q[i] <= flash_rd_pkg::Invalid;
      end
    end

    always_ff @(posedge clk_i) begin
      if (alloc_we[i]) begin
        addr_q[i] <= word_addr;
        err_q[i]  <= 1'b0;
      end else if (upd_we[i]) begin
        err_q[i]  <= upd_err_i;
        data_q[i] <= upd_data_i;
      end
    end

    assign entries_o[i] = '{state: state_q[i], addr: addr_q[i], err: err_q[i], data: data_q[i]};
  end

endmodule

//--- src/flash_rd_top.sv
// flash read pipeline top, joins buffers, read FSM, order FIFO and parity
// check between the bus request port and the flash macro
`timescale 1ns/1ns

module flash_rd_top #(
  parameter int unsigned NumBuf     = 4,
  parameter int unsigned OrderDepth = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  flash_rd_if_pkg::rd_req_t    req_i,
  output logic                        rdy_o,
  input  logic                        buf_en_i,
  output logic                        idle_o,
  output flash_rd_if_pkg::flash_req_t flash_o,
  input  flash_rd_if_pkg::flash_rsp_t flash_i,
  output flash_rd_if_pkg::rd_rsp_t    rsp_o
);

  localparam int unsigned WordAddrW = flash_rd_pkg::WordAddrW;

  logic                                  buf_en_q;
  logic                                  en_same;
  logic [WordAddrW-1:0]                  req_word;
  flash_rd_if_pkg::rd_req_t              buf_req;
  logic [NumBuf-1:0]                     hit;
  logic [NumBuf-1:0]                     alloc;
  logic                                  all_dep;
  flash_rd_pkg::buf_entry_t [NumBuf-1:0] entries;
  logic                                  fifo_full;
  logic                                  fifo_empty;
  logic [NumBuf-1:0]                     head_sel;
  logic                                  head_word;
  logic                                  head_ecc;
  logic [NumBuf-1:0]                     dep;
  logic                                  rd_busy;
  logic                                  rd_done;
  logic [WordAddrW-1:0]                  rd_addr;
  logic                                  rd_ecc;
  logic [NumBuf-1:0]                     rd_alloc;
  logic                                  flash_rdy;
  logic                                  miss;
  logic                                  par_err;
  logic                                  erased;
  logic                                  flash_err;
  logic [NumBuf-1:0]                     upd_sel;
  logic                                  flash_rsp_match;
  logic [NumBuf-1:0]                     buf_rsp_match;
  flash_rd_pkg::flash_data_u             src_data;
  logic                                  src_err;

  ////////////////////////////////////////////////////////////////////////////
  // buffer enable and request acceptance
  ////////////////////////////////////////////////////////////////////////////

  // the enable only moves while nothing is queued
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_en_q <= 1'b0;
    end else if (idle_o) begin
      buf_en_q <= buf_en_i;
    end
  end

  // hold the upstream off until a requested enable change has landed
  assign en_same   = (buf_en_q == buf_en_i);
  assign idle_o    = fifo_empty;
  assign req_word  = req_i.addr[flash_rd_pkg::BusAddrW-1 -: WordAddrW];
  assign miss      = ~|hit;
  assign flash_rdy = ~rd_busy | rd_done;

  // a miss also needs the flash free and the macro ready to take it
  assign rdy_o = ~fifo_full & ~all_dep & en_same & (~miss | (flash_i.ack & flash_rdy));

  assign flash_o.req  = req_i.req & rdy_o & miss;
  assign flash_o.addr = flash_o.req ? req_word : rd_addr;

  // side commands only count while idle
  always_comb begin
    buf_req          = req_i;
    buf_req.prog     = req_i.prog & idle_o;
    buf_req.pg_erase = req_i.pg_erase & idle_o;
    buf_req.bk_erase = req_i.bk_erase & idle_o;
  end

  flash_rd_buf_array #(
    .NumBuf(NumBuf)
  ) i_buf_array (
    .clk_i,
    .rst_ni,
    .en_i      (buf_en_q),
    .req_i     (buf_req),
    .accept_i  (req_i.req & rdy_o),
    .dep_i     (dep),
    .upd_sel_i (upd_sel),
    .upd_err_i (par_err),
    .upd_data_i(flash_i.word.data),
    .hit_o     (hit),
    .alloc_o   (alloc),
    .all_dep_o (all_dep),
    .entries_o (entries)
  );

  flash_rd_order_fifo #(
    .NumBuf    (NumBuf),
    .OrderDepth(OrderDepth)
  ) i_order_fifo (
    .clk_i,
    .rst_ni,
    .wr_i       (req_i.req & rdy_o),
    .wr_sel_i   (|alloc ? alloc : hit),
    .wr_word_i  (req_i.addr[0]),
    .wr_ecc_i   (req_i.ecc),
    .rd_i       (rsp_o.valid),
    .full_o     (fifo_full),
    .empty_o    (fifo_empty),
    .head_sel_o (head_sel),
    .head_word_o(head_word),
    .head_ecc_o (head_ecc),
    .dep_o      (dep)
  );

  ////////////////////////////////////////////////////////////////////////////
  // flash read and parity check
  ////////////////////////////////////////////////////////////////////////////

  flash_rd_ctrl #(
    .NumBuf(NumBuf)
  ) i_ctrl (
    .clk_i,
    .rst_ni,
    .start_i   (flash_o.req),
    .done_i    (flash_i.done),
    .addr_i    (req_word),
    .ecc_i     (req_i.ecc),
    .alloc_i   (alloc),
    .busy_o    (rd_busy),
    .rd_done_o (rd_done),
    .rd_addr_o (rd_addr),
    .rd_ecc_o  (rd_ecc),
    .rd_alloc_o(rd_alloc)
  );

  flash_rd_parity_chk i_parity_chk (
    .word_i   (flash_i.word),
    .par_err_o(par_err),
    .erased_o (erased)
  );

  // the buffer keeps the raw parity result, each response applies its own
  // ecc enable
  assign flash_err = rd_ecc & par_err & ~erased;
  assign upd_sel   = rd_done ? rd_alloc : '0;

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  // when the flash answers directly the head entry is the request that
  // started the read, so its ecc enable is the captured one
  assign flash_rsp_match = ~fifo_empty & rd_done & (~buf_en_q | (head_sel == rd_alloc));

  for (genvar i = 0; i < NumBuf; i++) begin : gen_rsp_match
    assign buf_rsp_match[i] = buf_en_q & ~fifo_empty & head_sel[i] &
                              (entries[i].state == flash_rd_pkg::Valid);
  end

  always_comb begin
    src_data = flash_i.word.data;
    src_err  = flash_err;
    for (int i = 0; i < NumBuf; i++) begin
      if (buf_rsp_match[i]) begin
        src_data = entries[i].data;
        src_err  = head_ecc & entries[i].err;
      end
    end
  end

  // an errored response carries all ones instead of the data
  always_comb begin
    rsp_o.valid = flash_rsp_match | |buf_rsp_match;
    rsp_o.err   = rsp_o.valid & src_err;
    rsp_o.data  = rsp_o.err ? '1 : src_data.words[head_word];
  end

endmodule

//--- tests/tb_flash_macro.sv
// behavioural flash macro for the read pipeline testbench, random ack and
// 1 to 4 cycle read latency over a word store the testbench can rewrite
`timescale 1ns/1ns

module tb_flash_macro (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  flash_rd_if_pkg::flash_req_t req_i,
  output flash_rd_if_pkg::flash_rsp_t rsp_o
);

  flash_rd_pkg::flash_word_t mem [1024];

  // data is a scramble of the whole word address with even byte parity
  function automatic flash_rd_pkg::flash_word_t fill_word(input int unsigned a);
    flash_rd_pkg::flash_word_t w;
    w.data.whole = {a * 32'h9e37_79b1 ^ 32'hc3a5_0f1e, a * 32'h7f4a_7c15 + 32'h1357_9bdf};
    for (int b = 0; b < 8; b++) begin
      w.par[b] = ^w.data.whole[8*b +: 8];
    end
    // some words get one parity bit flipped, some are left erased
    if (a % 13 == 5) w.par[a % 8] = ~w.par[a % 8];
    if (a % 11 == 7) w = '1;
    return w;
  endfunction

  task automatic program_word(input logic [9:0] addr, input flash_rd_pkg::flash_word_t w);
    mem[addr] = w;
  endtask

  task automatic erase_page(input logic [3:0] page);
    for (int a = 0; a < 1024; a++) begin
      if ((a >> 6) == page) mem[a] = '1;
    end
  endtask

  task automatic erase_bank();
    for (int a = 0; a < 1024; a++) begin
      mem[a] = '1;
    end
  endtask

  // request is sampled mid-cycle, outputs change just after the rising edge
  initial begin : respond
    logic        take;
    logic        rst_seen;
    logic        busy;
    logic [9:0]  take_addr;
    logic [9:0]  rd_addr;
    int unsigned left;
    for (int a = 0; a < 1024; a++) begin
      mem[a] = fill_word(a);
    end
    rsp_o   = '0;
    busy    = 1'b0;
    rd_addr = '0;
    left    = 0;
    forever begin
      @(negedge clk_i);
      rst_seen  = rst_ni;
      take      = rst_ni & req_i.req;
      take_addr = req_i.addr;
      @(posedge clk_i);
      #1;
      rsp_o.done = 1'b0;
      rsp_o.word = '0;
      rsp_o.ack  = rst_seen && (($urandom % 4) != 0);
      if (!rst_seen) begin
        busy = 1'b0;
      end else begin
        if (busy) begin
          left = left - 1;
          if (left == 0) begin
            busy       = 1'b0;
            rsp_o.done = 1'b1;
            rsp_o.word = mem[rd_addr];
          end
        end
        // a one cycle read answers right in the next cycle
        if (take) begin
          rd_addr = take_addr;
          left    = 1 + $urandom % 4;
          if (left == 1) begin
            rsp_o.done = 1'b1;
            rsp_o.word = mem[rd_addr];
          end else begin
            busy = 1'b1;
            left = left - 1;
          end
        end
      end
    end
  end

endmodule

//--- tests/tb_flash_rd.sv
// testbench for the flash read pipeline, random reads and side commands
// checked against a response queue built from the macro's word store
`timescale 1ns/1ns

module tb_flash_rd;

  localparam int unsigned NumReads   = 400;
  localparam int unsigned ClkPeriod  = 4;
  localparam int unsigned WatchdogNs = NumReads * 40 * ClkPeriod;
  localparam logic [9:0]  WinBase    = 10'd56;
  localparam int unsigned WinSize    = 16;
  localparam int          CmdProg    = 0;
  localparam int          CmdPage    = 1;
  localparam int          CmdBank    = 2;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        rdy;
  logic                        buf_en;
  logic                        idle;
  logic                        en_at_idle;
  flash_rd_if_pkg::rd_req_t    req;
  flash_rd_if_pkg::rd_rsp_t    rsp;
  flash_rd_if_pkg::flash_req_t flash_req;
  flash_rd_if_pkg::flash_rsp_t flash_rsp;
  flash_rd_if_pkg::rd_rsp_t    exp_q [$];
  int unsigned                 flash_reqs;
  int unsigned                 settle;

  flash_rd_top #(
    .NumBuf    (4),
    .OrderDepth(4)
  ) i_flash_rd_top (
    .clk_i,
    .rst_ni,
    .req_i   (req),
    .rdy_o   (rdy),
    .buf_en_i(buf_en),
    .idle_o  (idle),
    .flash_o (flash_req),
    .flash_i (flash_rsp),
    .rsp_o   (rsp)
  );

  tb_flash_macro i_macro (
    .clk_i,
    .rst_ni,
    .req_i(flash_req),
    .rsp_o(flash_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [7:0] byte_parity(input logic [63:0] d);
    logic [7:0] p;
    for (int b = 0; b < 8; b++) begin
      p[b] = ^d[8*b +: 8];
    end
    return p;
  endfunction

  // an erased word is clean whatever its parity bits say
  function automatic logic word_bad(input logic [71:0] w);
    return (w != '1) && (w[71:64] != byte_parity(w[63:0]));
  endfunction

  function automatic flash_rd_if_pkg::rd_rsp_t expect_rsp(input logic [71:0] w,
                                                          input logic sel, input logic ecc);
    flash_rd_if_pkg::rd_rsp_t r;
    r.valid = 1'b1;
    r.err   = ecc & word_bad(w);
    r.data  = r.err ? '1 : (sel ? w[63:32] : w[31:0]);
    return r;
  endfunction

  task automatic report_failure();
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
    report_failure();
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    report_failure();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor and checks
  ////////////////////////////////////////////////////////////////////////////

  // everything is sampled mid-cycle, well after the inputs have moved
  initial begin : monitor
    flash_rd_if_pkg::rd_rsp_t want;
    flash_reqs = 0;
    settle     = 0;
    en_at_idle = 1'b0;
    forever begin
      @(negedge clk_i);
      // quiet outputs through reset and the first cycles after it
      if (!rst_ni || settle < 2) begin
        assert (!rsp.valid) else show_mismatch("rsp_o.valid", rsp.valid, 0);
        assert (!flash_req.req) else show_mismatch("flash_o.req", flash_req.req, 0);
        assert (idle) else show_mismatch("idle_o", idle, 1);
      end
      if (rst_ni && settle < 2) settle++;
      if (flash_req.req) begin
        flash_reqs++;
        assert (flash_rsp.ack) else report_error("flash request raised without ack");
        assert (flash_req.addr == req.addr[10:1])
          else show_mismatch("flash_o.addr", flash_req.addr, req.addr[10:1]);
      end
      if (rsp.valid) begin
        assert (exp_q.size() > 0) else report_error("response with no read pending");
        want = exp_q.pop_front();
        assert (rsp.err == want.err) else show_mismatch("rsp_o.err", rsp.err, want.err);
        assert (rsp.data == want.data) else show_mismatch("rsp_o.data", rsp.data, want.data);
      end
      if (req.req && rdy) begin
        assert (buf_en == en_at_idle)
          else report_error("read accepted before an enable change saw idle");
        assert (buf_en || flash_req.req)
          else report_error("read accepted with buffering off raised no flash request");
        exp_q.push_back(expect_rsp(i_macro.mem[req.addr[10:1]], req.addr[0], req.ecc));
      end
      // the registered enable only takes the input at the end of an idle cycle
      if (idle) en_at_idle = buf_en;
    end
  end

  initial begin : watchdog
    #(WatchdogNs);
    report_error("watchdog expired before all reads were answered");
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // holds the read until it is taken, returns just after the taking edge
  task automatic send_read(input logic [9:0] waddr, input logic sel, input logic ecc);
    req.req  = 1'b1;
    req.addr = {waddr, sel};
    req.ecc  = ecc;
    do begin
      @(negedge clk_i);
    end while (!rdy);
    @(posedge clk_i);
    #1;
    req.req = 1'b0;
  endtask

  task automatic wait_idle();
    do begin
      @(negedge clk_i);
    end while (!idle);
    @(posedge clk_i);
    #1;
  endtask

  task automatic set_enable(input logic en);
    wait_idle();
    buf_en = en;
  endtask

  // the store changes in the same cycle the command is seen by the DUT
  task automatic side_cmd(input int kind, input logic [9:0] waddr);
    flash_rd_pkg::flash_word_t w;
    wait_idle();
    w.data.whole = {$urandom, $urandom};
    w.par        = byte_parity(w.data.whole);
    // one programmed word in four carries a broken parity bit
    if (($urandom % 4) == 0) w.par[0] = ~w.par[0];
    req.addr = {waddr, 1'b0};
    case (kind)
      CmdProg: begin
        req.prog = 1'b1;
        i_macro.program_word(waddr, w);
      end
      CmdPage: begin
        req.pg_erase = 1'b1;
        i_macro.erase_page(waddr[9:6]);
      end
      default: begin
        req.bk_erase = 1'b1;
        i_macro.erase_bank();
      end
    endcase
    @(posedge clk_i);
    #1;
    req.prog     = 1'b0;
    req.pg_erase = 1'b0;
    req.bk_erase = 1'b0;
  endtask

  task automatic check_flash_reqs(input int unsigned from, input int unsigned want);
    assert (flash_reqs - from == want)
      else show_mismatch("flash_o.req count", flash_reqs - from, want);
  endtask

  initial begin : stimulus
    logic [9:0]  clean;
    logic [9:0]  waddr;
    int unsigned from;
    int unsigned pick;
    void'($urandom(32'hc69d));
    req    = '0;
    buf_en = 1'b0;
    rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // first word of the window with real data and good parity
    clean = WinBase;
    while (word_bad(i_macro.mem[clean]) || i_macro.mem[clean] == '1) begin
      clean = clean + 1'b1;
    end

    // four reads of one word cost a single flash read
    set_enable(1'b1);
    from = flash_reqs;
    send_read(clean, 1'b0, 1'b1);
    send_read(clean, 1'b1, 1'b1);
    send_read(clean, 1'b0, 1'b0);
    send_read(clean, 1'b1, 1'b1);
    wait_idle();
    check_flash_reqs(from, 1);

    // program and page erase wipe the buffered copy
    side_cmd(CmdProg, clean);
    from = flash_reqs;
    send_read(clean, 1'b1, 1'b1);
    wait_idle();
    check_flash_reqs(from, 1);
    side_cmd(CmdPage, clean);
    from = flash_reqs;
    send_read(clean, 1'b0, 1'b1);
    wait_idle();
    check_flash_reqs(from, 1);

    // with buffering off every read goes to the flash
    set_enable(1'b0);
    from = flash_reqs;
    repeat (3) send_read(clean + 1'b1, 1'b0, 1'b1);
    wait_idle();
    check_flash_reqs(from, 3);
    set_enable(1'b1);

    for (int i = 0; i < NumReads; i++) begin
      pick = $urandom % 64;
      if (pick == 0) begin
        set_enable(~buf_en);
      end else if (pick < 8) begin
        side_cmd(CmdProg, WinBase + 10'($urandom % WinSize));
      end else if (pick == 8) begin
        side_cmd(CmdPage, WinBase + 10'($urandom % WinSize));
      end
      if (i == NumReads - 50) side_cmd(CmdBank, '0);
      waddr = WinBase + 10'($urandom % WinSize);
      send_read(waddr, 1'($urandom % 2), ($urandom % 4) != 0);
      // gaps now and then let queued hits drain between reads
      if (($urandom % 4) == 0) begin
        repeat (1 + $urandom % 3) @(posedge clk_i);
        #1;
      end
    end

    wait_idle();
    if (exp_q.size() == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      report_error("reads left without a response at the end of the run");
    end
  end

endmodule

//--- files.f
src/flash_rd_pkg.sv
src/flash_rd_if_pkg.sv
src/flash_rd_ctrl.sv
src/flash_rd_repl_ptr.sv
src/flash_rd_parity_chk.sv
src/flash_rd_order_fifo.sv
src/flash_rd_buf_array.sv
src/flash_rd_top.sv
tests/tb_flash_macro.sv
tests/tb_flash_rd.sv
